// File: rtl/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // data and address word
    typedef logic [XLEN-1:0] word_t;

    // register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // byte distance between two instructions
    localparam word_t PC_STEP = 32'd4;

    // reset address unless the top level overrides it
    localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // alu operation code
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // major opcodes of the supported subset
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // funct3 values
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_WORD    = 3'b010;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    // funct7 values for register ops
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  core_pkg::word_t redirect_pc_i,
    input  core_pkg::word_t inst_i,
    output core_pkg::word_t pc_o,
    output logic            id_valid_o,
    output core_pkg::word_t id_pc_o,
    output core_pkg::word_t id_inst_o
);

    core_pkg::word_t pc_q;

    assign pc_o = pc_q;

    // pc and decode valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            id_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // younger instruction is on the wrong path
            pc_q       <= redirect_pc_i;
            id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q       <= pc_q + core_pkg::PC_STEP;
            id_valid_o <= 1'b1;
        end
    end

    // rom data arrives in the same cycle as the pc
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= inst_i;
        end
    end

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                redirect_i,
    input  logic                id_valid_i,
    input  core_pkg::word_t     id_pc_i,
    input  core_pkg::word_t     id_inst_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    input  logic                wb_we_i,
    input  core_pkg::reg_addr_t wb_addr_i,
    input  core_pkg::word_t     wb_data_i,
    output logic                ex_valid_o,
    output core_pkg::word_t     ex_pc_o,
    output core_pkg::word_t     ex_rs1_o,
    output core_pkg::word_t     ex_rs2_o,
    output core_pkg::word_t     ex_imm_o,
    output isa_pkg::alu_op_t    ex_alu_op_o,
    output logic                ex_use_imm_o,
    output logic                ex_rd_we_o,
    output core_pkg::reg_addr_t ex_rd_o,
    output logic                ex_load_o,
    output logic                ex_store_o,
    output logic                ex_beq_o,
    output logic                ex_bne_o,
    output logic                ex_jal_o
);

    isa_pkg::opcode_t opcode;
    isa_pkg::funct3_t funct3;
    isa_pkg::funct7_t funct7;

    core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    core_pkg::word_t rs1_val, rs2_val;

    logic             dec_known;
    core_pkg::word_t  dec_imm;
    isa_pkg::alu_op_t dec_alu_op;
    logic             dec_use_imm;
    logic             dec_rd_we;
    logic             dec_load, dec_store, dec_beq, dec_bne, dec_jal;

    assign opcode     = id_inst_i[6:0];
    assign funct3     = id_inst_i[14:12];
    assign funct7     = id_inst_i[31:25];
    assign rs1_addr_o = id_inst_i[19:15];
    assign rs2_addr_o = id_inst_i[24:20];

    assign imm_i = {{20{id_inst_i[31]}}, id_inst_i[31:20]};
    assign imm_s = {{20{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
    assign imm_b = {{19{id_inst_i[31]}}, id_inst_i[31], id_inst_i[7],
                    id_inst_i[30:25], id_inst_i[11:8], 1'b0};
    assign imm_u = {id_inst_i[31:12], 12'b0};
    assign imm_j = {{11{id_inst_i[31]}}, id_inst_i[31], id_inst_i[19:12],
                    id_inst_i[20], id_inst_i[30:21], 1'b0};

    // bypass the result being written back this cycle
    assign rs1_val = (wb_we_i && wb_addr_i != '0 && wb_addr_i == rs1_addr_o)
                   ? wb_data_i : rs1_data_i;
    assign rs2_val = (wb_we_i && wb_addr_i != '0 && wb_addr_i == rs2_addr_o)
                   ? wb_data_i : rs2_data_i;

    always_comb begin
        dec_known   = 1'b0;
        dec_imm     = imm_i;
        dec_alu_op  = isa_pkg::ALU_ADD;
        dec_use_imm = 1'b0;
        dec_rd_we   = 1'b0;
        dec_load    = 1'b0;
        dec_store   = 1'b0;
        dec_beq     = 1'b0;
        dec_bne     = 1'b0;
        dec_jal     = 1'b0;
        case (opcode)
            isa_pkg::OP_IMM: begin
                // addi only
                dec_known   = (funct3 == isa_pkg::F3_ADD_SUB);
                dec_use_imm = 1'b1;
                dec_rd_we   = 1'b1;
            end
            isa_pkg::OP_REG: begin
                dec_rd_we = 1'b1;
                if (funct7 == isa_pkg::F7_BASE) begin
                    dec_known = 1'b1;
                    case (funct3)
                        isa_pkg::F3_ADD_SUB: dec_alu_op = isa_pkg::ALU_ADD;
                        isa_pkg::F3_XOR:     dec_alu_op = isa_pkg::ALU_XOR;
                        isa_pkg::F3_OR:      dec_alu_op = isa_pkg::ALU_OR;
                        isa_pkg::F3_AND:     dec_alu_op = isa_pkg::ALU_AND;
                        default:             dec_known  = 1'b0;
                    endcase
                end else if (funct7 == isa_pkg::F7_ALT) begin
                    dec_known  = (funct3 == isa_pkg::F3_ADD_SUB);
                    dec_alu_op = isa_pkg::ALU_SUB;
                end
            end
            isa_pkg::OP_LUI: begin
                dec_known   = 1'b1;
                dec_imm     = imm_u;
                dec_alu_op  = isa_pkg::ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_rd_we   = 1'b1;
            end
            isa_pkg::OP_LOAD: begin
                // address goes through the alu
                dec_known   = (funct3 == isa_pkg::F3_WORD);
                dec_use_imm = 1'b1;
                dec_rd_we   = 1'b1;
                dec_load    = 1'b1;
            end
            isa_pkg::OP_STORE: begin
                dec_known   = (funct3 == isa_pkg::F3_WORD);
                dec_imm     = imm_s;
                dec_use_imm = 1'b1;
                dec_store   = 1'b1;
            end
            isa_pkg::OP_BRANCH: begin
                dec_known = (funct3 == isa_pkg::F3_BEQ) || (funct3 == isa_pkg::F3_BNE);
                dec_imm   = imm_b;
                dec_beq   = (funct3 == isa_pkg::F3_BEQ);
                dec_bne   = (funct3 == isa_pkg::F3_BNE);
            end
            isa_pkg::OP_JAL: begin
                dec_known = 1'b1;
                dec_imm   = imm_j;
                dec_rd_we = 1'b1;
                dec_jal   = 1'b1;
            end
            default: dec_known = 1'b0;
        endcase
    end

    // execute register, control part
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_rd_we_o <= 1'b0;
            ex_load_o  <= 1'b0;
            ex_store_o <= 1'b0;
            ex_beq_o   <= 1'b0;
            ex_bne_o   <= 1'b0;
            ex_jal_o   <= 1'b0;
        end else if (redirect_i) begin
            ex_valid_o <= 1'b0;
        end else if (!stall_i) begin
            // unknown opcodes turn into bubbles
            ex_valid_o <= id_valid_i && dec_known;
            ex_rd_we_o <= dec_rd_we;
            ex_load_o  <= dec_load;
            ex_store_o <= dec_store;
            ex_beq_o   <= dec_beq;
            ex_bne_o   <= dec_bne;
            ex_jal_o   <= dec_jal;
        end
    end

    // execute register, operands
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_pc_o      <= id_pc_i;
            ex_rs1_o     <= rs1_val;
            ex_rs2_o     <= rs2_val;
            ex_imm_o     <= dec_imm;
            ex_alu_op_o  <= dec_alu_op;
            ex_use_imm_o <= dec_use_imm;
            ex_rd_o      <= id_inst_i[11:7];
        end
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle writes reach decode through its own bypass
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                ex_valid_i,
    input  core_pkg::word_t     ex_pc_i,
    input  core_pkg::word_t     ex_rs1_i,
    input  core_pkg::word_t     ex_rs2_i,
    input  core_pkg::word_t     ex_imm_i,
    input  isa_pkg::alu_op_t    ex_alu_op_i,
    input  logic                ex_use_imm_i,
    input  logic                ex_rd_we_i,
    input  core_pkg::reg_addr_t ex_rd_i,
    input  logic                ex_load_i,
    input  logic                ex_store_i,
    input  logic                ex_beq_i,
    input  logic                ex_bne_i,
    input  logic                ex_jal_i,
    input  core_pkg::word_t     ram_data_i,
    input  logic                ram_data_rvalid_i,
    output logic                ram_ce_o,
    output logic                ram_we_o,
    output core_pkg::word_t     ram_addr_o,
    output core_pkg::word_t     ram_data_o,
    output logic                stall_o,
    output logic                redirect_o,
    output core_pkg::word_t     redirect_pc_o,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o
);

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT_LOAD
    } mem_state_t;

    mem_state_t      mem_state, mem_state_nxt;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_res;
    logic            br_taken;
    logic            load_done;

    assign op_b = ex_use_imm_i ? ex_imm_i : ex_rs2_i;

    always_comb begin
        case (ex_alu_op_i)
            isa_pkg::ALU_SUB:    alu_res = ex_rs1_i - op_b;
            isa_pkg::ALU_AND:    alu_res = ex_rs1_i & op_b;
            isa_pkg::ALU_OR:     alu_res = ex_rs1_i | op_b;
            isa_pkg::ALU_XOR:    alu_res = ex_rs1_i ^ op_b;
            isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:             alu_res = ex_rs1_i + op_b;
        endcase
    end

    // predicted not taken, so any taken branch redirects
    assign br_taken      = (ex_beq_i && ex_rs1_i == ex_rs2_i) ||
                           (ex_bne_i && ex_rs1_i != ex_rs2_i);
    assign redirect_o    = ex_valid_i && (br_taken || ex_jal_i);
    assign redirect_pc_o = ex_pc_i + ex_imm_i;

    // load waits for the memory valid pulse
    always_comb begin
        mem_state_nxt = mem_state;
        case (mem_state)
            MEM_IDLE: begin
                if (ex_valid_i && ex_load_i) begin
                    mem_state_nxt = MEM_WAIT_LOAD;
                end
            end
            MEM_WAIT_LOAD: begin
                if (ram_data_rvalid_i) begin
                    mem_state_nxt = MEM_IDLE;
                end
            end
            default: mem_state_nxt = MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_state <= MEM_IDLE;
        end else begin
            mem_state <= mem_state_nxt;
        end
    end

    assign load_done = (mem_state == MEM_WAIT_LOAD) && ram_data_rvalid_i;
    assign stall_o   = ex_valid_i && ex_load_i && !load_done;

    // store is a one-cycle strobe, load holds ce until data returns
    assign ram_ce_o   = ex_valid_i && (ex_load_i || ex_store_i);
    assign ram_we_o   = ex_valid_i && ex_store_i;
    assign ram_addr_o = alu_res;
    assign ram_data_o = ex_rs2_i;

    assign wb_we_o   = ex_valid_i && ex_rd_we_i && (!ex_load_i || load_done);
    assign wb_addr_o = ex_rd_i;

    always_comb begin
        if (ex_load_i) begin
            wb_data_o = ram_data_i;
        end else if (ex_jal_i) begin
            // link address
            wb_data_o = ex_pc_i + core_pkg::PC_STEP;
        end else begin
            wb_data_o = alu_res;
        end
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::word_t RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    output core_pkg::word_t rom_addr_o,
    input  core_pkg::word_t rom_data_i,
    output logic            ram_ce_o,
    output logic            ram_we_o,
    output core_pkg::word_t ram_addr_o,
    output core_pkg::word_t ram_data_o,
    input  core_pkg::word_t ram_data_i,
    input  logic            ram_data_rvalid_i
);

    // control from execute
    logic            stall;
    logic            redirect;
    core_pkg::word_t redirect_pc;

    // fetch to decode
    logic            id_valid;
    core_pkg::word_t id_pc;
    core_pkg::word_t id_inst;

    // decode and register file
    core_pkg::reg_addr_t rs1_addr, rs2_addr;
    core_pkg::word_t     rs1_data, rs2_data;

    // decode to execute
    logic                ex_valid;
    core_pkg::word_t     ex_pc, ex_rs1, ex_rs2, ex_imm;
    isa_pkg::alu_op_t    ex_alu_op;
    logic                ex_use_imm, ex_rd_we;
    core_pkg::reg_addr_t ex_rd;
    logic                ex_load, ex_store, ex_beq, ex_bne, ex_jal;

    // writeback, also bypassed into decode
    logic                wb_we;
    core_pkg::reg_addr_t wb_addr;
    core_pkg::word_t     wb_data;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .inst_i       (rom_data_i),
        .pc_o         (rom_addr_o),
        .id_valid_o   (id_valid),
        .id_pc_o      (id_pc),
        .id_inst_o    (id_inst)
    );

    decoder decode_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .id_valid_i  (id_valid),
        .id_pc_i     (id_pc),
        .id_inst_i   (id_inst),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .wb_we_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .ex_valid_o  (ex_valid),
        .ex_pc_o     (ex_pc),
        .ex_rs1_o    (ex_rs1),
        .ex_rs2_o    (ex_rs2),
        .ex_imm_o    (ex_imm),
        .ex_alu_op_o (ex_alu_op),
        .ex_use_imm_o(ex_use_imm),
        .ex_rd_we_o  (ex_rd_we),
        .ex_rd_o     (ex_rd),
        .ex_load_o   (ex_load),
        .ex_store_o  (ex_store),
        .ex_beq_o    (ex_beq),
        .ex_bne_o    (ex_bne),
        .ex_jal_o    (ex_jal)
    );

    regfile regfile_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (wb_we),
        .waddr_i (wb_addr),
        .wdata_i (wb_data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    exec_unit exec_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ex_valid_i       (ex_valid),
        .ex_pc_i          (ex_pc),
        .ex_rs1_i         (ex_rs1),
        .ex_rs2_i         (ex_rs2),
        .ex_imm_i         (ex_imm),
        .ex_alu_op_i      (ex_alu_op),
        .ex_use_imm_i     (ex_use_imm),
        .ex_rd_we_i       (ex_rd_we),
        .ex_rd_i          (ex_rd),
        .ex_load_i        (ex_load),
        .ex_store_i       (ex_store),
        .ex_beq_i         (ex_beq),
        .ex_bne_i         (ex_bne),
        .ex_jal_i         (ex_jal),
        .ram_data_i       (ram_data_i),
        .ram_data_rvalid_i(ram_data_rvalid_i),
        .ram_ce_o         (ram_ce_o),
        .ram_we_o         (ram_we_o),
        .ram_addr_o       (ram_addr_o),
        .ram_data_o       (ram_data_o),
        .stall_o          (stall),
        .redirect_o       (redirect),
        .redirect_pc_o    (redirect_pc),
        .wb_we_o          (wb_we),
        .wb_addr_o        (wb_addr),
        .wb_data_o        (wb_data)
    );

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DONE_TIMEOUT = 500;
    localparam int ROM_WORDS    = 64;
    localparam int RAM_WORDS    = 64;

    // core_top keeps its default reset address
    localparam core_pkg::word_t RESET_PC  = 32'h0000_0000;
    localparam core_pkg::word_t DONE_ADDR = 32'h0000_0100;
    localparam logic [11:0]     BAD_IMM   = 12'h0F0;

    // rv32i encodings, kept apart from the rtl packages
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    logic            clk_i;
    logic            rst_n_i = 1'b0;
    core_pkg::word_t rom_addr_o;
    core_pkg::word_t rom_data_i;
    logic            ram_ce_o;
    logic            ram_we_o;
    core_pkg::word_t ram_addr_o;
    core_pkg::word_t ram_data_o;
    core_pkg::word_t ram_data_i = '0;
    logic            ram_data_rvalid_i = 1'b0;

    core_pkg::word_t rom [ROM_WORDS];
    core_pkg::word_t ram_mem [RAM_WORDS];
    int              rom_fill;

    // memory model state
    logic            load_busy;
    logic [1:0]      load_wait;
    core_pkg::word_t load_addr;
    logic            done_seen;
    logic [15:0]     lfsr_state = 16'd40149;

    core_pkg::word_t store_addr_q[$];
    core_pkg::word_t store_data_q[$];
    core_pkg::word_t exp_addr_q[$];
    core_pkg::word_t exp_data_q[$];

    core_top dut_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .rom_addr_o       (rom_addr_o),
        .rom_data_i       (rom_data_i),
        .ram_ce_o         (ram_ce_o),
        .ram_we_o         (ram_we_o),
        .ram_addr_o       (ram_addr_o),
        .ram_data_o       (ram_data_o),
        .ram_data_i       (ram_data_i),
        .ram_data_rvalid_i(ram_data_rvalid_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // instruction memory answers within the cycle
    assign rom_data_i = rom[rom_addr_o[7:2]];

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // galois lfsr, one step per bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic core_pkg::word_t addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, F3_ADD, rd, OPC_IMM};
    endfunction

    function automatic core_pkg::word_t lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic core_pkg::word_t sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic core_pkg::word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic core_pkg::word_t branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                               input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic core_pkg::word_t lui(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, OPC_LUI};
    endfunction

    function automatic core_pkg::word_t jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // data memory: stores are logged, loads answer after 1 to 4 cycles
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            ram_data_rvalid_i <= 1'b0;
            load_busy = 1'b0;
            load_wait = 2'd0;
            done_seen = 1'b0;
            store_addr_q.delete();
            store_data_q.delete();
        end else begin
            if (ram_ce_o && ram_we_o) begin
                if (ram_addr_o == DONE_ADDR) begin
                    done_seen = 1'b1;
                end else begin
                    store_addr_q.push_back(ram_addr_o);
                    store_data_q.push_back(ram_data_o);
                end
            end
            if (ram_data_rvalid_i) begin
                ram_data_rvalid_i <= 1'b0;
                load_busy = 1'b0;
            end else if (ram_ce_o && !ram_we_o) begin
                if (!load_busy) begin
                    load_busy    = 1'b1;
                    load_addr    = ram_addr_o;
                    load_wait[1] = next_random_bit();
                    load_wait[0] = next_random_bit();
                end else begin
                    assert (ram_addr_o == load_addr) else fail_now($sformatf(
                        "Mismatch ram_addr_o during load: got 0x%08h, expected 0x%08h",
                        ram_addr_o, load_addr));
                    load_wait = load_wait - 2'd1;
                end
                if (load_wait == 2'd0) begin
                    ram_data_rvalid_i <= 1'b1;
                    ram_data_i        <= ram_mem[ram_addr_o[7:2]];
                end
            end
        end
    end

    task automatic emit(input core_pkg::word_t inst);
        rom[rom_fill] = inst;
        rom_fill++;
    endtask

    task automatic expect_store(input core_pkg::word_t addr, input core_pkg::word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic hold_reset();
        @(posedge clk_i);
        rst_n_i <= 1'b0;
    endtask

    // nop fill whose immediate is the word address
    task automatic new_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = addi(5'd0, 5'd0, 12'(i * 4));
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_mem[i] = 32'hA5A5_0000 | 32'(i * 4);
        end
        rom_fill = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic release_reset();
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk_i);
            assert (!ram_ce_o && !ram_we_o) else fail_now("RAM strobe active during reset");
        end
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        assert (rom_addr_o == RESET_PC) else fail_now($sformatf(
            "Mismatch rom_addr_o after reset: got 0x%08h, expected 0x%08h",
            rom_addr_o, RESET_PC));
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done_seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (done_seen) else fail_now($sformatf("%s: timed out waiting for the done store",
            name));
        @(negedge clk_i);
    endtask

    task automatic check_stores(input string name);
        assert (store_addr_q.size() <= exp_addr_q.size()) else fail_now($sformatf(
            "%s: extra store, %0d seen but %0d expected", name, store_addr_q.size(),
            exp_addr_q.size()));
        assert (store_addr_q.size() >= exp_addr_q.size()) else fail_now($sformatf(
            "%s: missing store, %0d seen but %0d expected", name, store_addr_q.size(),
            exp_addr_q.size()));
        for (int k = 0; k < exp_addr_q.size(); k++) begin
            assert (store_addr_q[k] == exp_addr_q[k]) else fail_now($sformatf(
                "Mismatch ram_addr_o (%s store %0d): got 0x%08h, expected 0x%08h",
                name, k, store_addr_q[k], exp_addr_q[k]));
            assert (store_data_q[k] == exp_data_q[k]) else fail_now($sformatf(
                "Mismatch ram_data_o (%s store %0d): got 0x%08h, expected 0x%08h",
                name, k, store_data_q[k], exp_data_q[k]));
        end
    endtask

    // done store, then spin on a jump to itself
    task automatic run_program(input string name);
        emit(sw(5'd0, 5'd0, DONE_ADDR[11:0]));
        emit(jal(5'd0, 21'd0));
        release_reset();
        wait_done(name);
        check_stores(name);
    endtask

    task automatic test_alu_forwarding();
        core_pkg::word_t v [1:9];
        hold_reset();
        new_program();
        v[1] = 32'h0000_0123;
        v[2] = v[1] + 32'hFFFF_FFFB;
        v[3] = v[1] + v[2];
        v[4] = v[2] - v[3];
        v[5] = v[4] & v[3];
        v[6] = v[5] | v[1];
        v[7] = v[6] ^ v[4];
        v[8] = 32'hABCD_E000;
        v[9] = v[8] + v[7];
        // dependent chain with no gaps
        emit(addi(5'd1, 5'd0, 12'h123));
        emit(addi(5'd2, 5'd1, 12'hFFB));
        emit(reg_op(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
        emit(reg_op(F7_SUB, F3_ADD, 5'd4, 5'd2, 5'd3));
        emit(reg_op(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd3));
        emit(reg_op(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd1));
        emit(reg_op(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4));
        emit(lui(5'd8, 20'hABCDE));
        emit(reg_op(F7_BASE, F3_ADD, 5'd9, 5'd8, 5'd7));
        for (int k = 1; k <= 9; k++) begin
            emit(sw(5'(k), 5'd0, 12'(4 * k)));
            expect_store(32'(4 * k), v[k]);
        end
        // x0 must ignore the write and the bypass
        emit(addi(5'd0, 5'd1, 12'd77));
        emit(sw(5'd0, 5'd0, 12'h040));
        expect_store(32'h0000_0040, 32'h0);
        run_program("alu");
    endtask

    task automatic test_loads();
        core_pkg::word_t vals [4];
        core_pkg::word_t sum;
        hold_reset();
        new_program();
        vals[0] = 32'h1111_0001;
        vals[1] = 32'h7FFF_FFF0;
        vals[2] = 32'hDEAD_BEEF;
        vals[3] = 32'h0000_0042;
        sum = '0;
        emit(addi(5'd10, 5'd0, 12'h040));
        for (int k = 0; k < 4; k++) begin
            ram_mem[16 + k] = vals[k];
            sum = sum + vals[k];
            emit(lw(5'd11, 5'd10, 12'(4 * k)));
            emit(reg_op(F7_BASE, F3_ADD, 5'd12, 5'd12, 5'd11));
            emit(sw(5'd12, 5'd0, 12'(128 + 4 * k)));
            expect_store(32'(128 + 4 * k), sum);
        end
        run_program("load");
    endtask

    task automatic test_branches();
        core_pkg::word_t jal_pc;
        hold_reset();
        new_program();
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd7));
        // beq taken over two wrong-path stores
        emit(branch(F3_BEQ, 5'd1, 5'd2, 13'd12));
        emit(sw(5'd1, 5'd0, BAD_IMM));
        emit(sw(5'd2, 5'd0, BAD_IMM));
        emit(branch(F3_BEQ, 5'd1, 5'd3, 13'd8));
        emit(sw(5'd3, 5'd0, 12'h010));
        expect_store(32'h0000_0010, 32'd7);
        emit(branch(F3_BNE, 5'd1, 5'd3, 13'd12));
        emit(sw(5'd1, 5'd0, BAD_IMM));
        emit(sw(5'd2, 5'd0, BAD_IMM));
        // bne not taken falls through
        emit(branch(F3_BNE, 5'd1, 5'd2, 13'd8));
        emit(sw(5'd1, 5'd0, 12'h014));
        expect_store(32'h0000_0014, 32'd5);
        jal_pc = RESET_PC + 32'(rom_fill * 4);
        emit(jal(5'd5, 21'd12));
        emit(sw(5'd1, 5'd0, BAD_IMM));
        emit(sw(5'd2, 5'd0, BAD_IMM));
        emit(sw(5'd5, 5'd0, 12'h018));
        expect_store(32'h0000_0018, jal_pc + 32'd4);
        run_program("branch");
    endtask

    initial begin
        test_alu_forwarding();
        test_loads();
        test_branches();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: files.f
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/exec_unit.sv
rtl/core_top.sv
verif/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
